/* hdl/flowMux_config.svh */
/* Flow multiplexer configuration
   Flow count and beat width shared by the package and the testbench */

`ifndef FLOW_MUX_CONFIG_SVH
`define FLOW_MUX_CONFIG_SVH

// -------------------------------------------------
// Flow multiplexer sizing
// -------------------------------------------------

// Number of push flows feeding the multiplexer
`define FLOW_MUX_NUM_FLOWS 4

// Data width of one beat on any push flow
`define FLOW_MUX_WIDTH 16

// Flow index width follows from the flow count
// and is derived in the package

`endif

/* hdl/flowMuxPkg.sv */
/* Flow multiplexer package
   Mask, index, data and tagged payload types shared by all blocks */

`include "flowMux_config.svh"

package flowMuxPkg;

  // -------------------------------------------------
  // Sizes
  // -------------------------------------------------

  localparam int NumFlows = `FLOW_MUX_NUM_FLOWS;
  localparam int DataWidth = `FLOW_MUX_WIDTH;

  // At least one bit, even for a single flow
  localparam int FlowIdWidth = (NumFlows > 1) ? $clog2(NumFlows) : 1;

  // -------------------------------------------------
  // Types
  // -------------------------------------------------

  // One bit per flow: valid, ready, request, grant
  typedef logic [NumFlows-1:0] flowMaskT;

  // Index of a single flow
  typedef logic [FlowIdWidth-1:0] flowIdT;

  // One data beat
  typedef logic [DataWidth-1:0] flowDataT;

  // Push data of all flows, flow 0 in the low slot
  typedef flowDataT [NumFlows-1:0] flowDataArrayT;

  // Popped beat tagged with the flow it came from
  typedef struct packed {
    flowIdT flowId;
    flowDataT data;
  } flowPayloadT;

endpackage

/* hdl/roundRobinArbiter.sv */
/* Round-robin arbiter
   One-hot grant searched upward from a registered priority pointer */

`timescale 1ns/1ps

module roundRobinArbiter (
  input  logic                clk,
  input  logic                reset,
  input  flowMuxPkg::flowMaskT request,
  input  logic                enablePriorityUpdate,
  output flowMuxPkg::flowMaskT grant
);

  import flowMuxPkg::*;

  // Highest-priority flow for the current cycle
  flowIdT priorityPtr;

  // Index of the granted flow, valid when any request is present
  flowIdT grantIdx;

  // Pointer value after a taken grant
  flowIdT nextPtr;

  // Search state
  int candidate;
  logic found;

  // -------------------------------------------------
  // Grant search
  // -------------------------------------------------

  // Walk the flows starting at the pointer, wrapping past the top
  // First requester found wins
  always_comb begin
    grant = '0;
    grantIdx = '0;
    found = 1'b0;
    candidate = 0;
    for (int offset = 0; offset < NumFlows; offset++) begin
      candidate = (int'(priorityPtr) + offset) % NumFlows;
      if (!found && request[candidate]) begin
        grant[candidate] = 1'b1;
        grantIdx = flowIdT'(candidate);
        found = 1'b1;
      end
    end
  end

  // -------------------------------------------------
  // Priority pointer
  // -------------------------------------------------

  // Flow just after the granted one, with wrap-around
  assign nextPtr = (grantIdx == flowIdT'(NumFlows - 1)) ? '0 : grantIdx + flowIdT'(1);

  // Moves only when the grant is actually taken
  // otherwise a stalled winner keeps its turn
  always_ff @(posedge clk) begin
    if (reset) begin
      priorityPtr <= '0;
    end else if (enablePriorityUpdate) begin
      priorityPtr <= nextPtr;
    end
  end

endmodule

/* hdl/flowMuxCore.sv */
/* Flow multiplexer core
   Applies the arbiter grant as push flow control and selects tagged data */

`timescale 1ns/1ps

module flowMuxCore (
  // Push flows
  input  flowMuxPkg::flowMaskT      pushValid,
  input  flowMuxPkg::flowDataArrayT pushData,
  output flowMuxPkg::flowMaskT      pushReady,
  // Arbiter side
  output flowMuxPkg::flowMaskT      request,
  input  flowMuxPkg::flowMaskT      grant,
  output logic                      enablePriorityUpdate,
  // Pop flow, combinational from push
  input  logic                      popReady,
  output logic                      popValid,
  output flowMuxPkg::flowPayloadT   popPayload
);

  import flowMuxPkg::*;

  // Data of the granted flow
  flowDataT selData;

  // Index of the granted flow
  flowIdT selId;

  // -------------------------------------------------
  // Requests and pop valid
  // -------------------------------------------------

  // Every waiting beat requests the arbiter
  assign request = pushValid;

  // Arbiter always grants when any request is present,
  // so any valid flow means a beat is offered
  assign popValid = |pushValid;

  // -------------------------------------------------
  // Push flow control
  // -------------------------------------------------

  // Only the granted flow sees ready,
  // and only while the pop side accepts
  always_comb begin
    pushReady = '0;
    if (popReady) begin
      pushReady = grant;
    end
  end

  // Grant taken means the pointer may advance
  assign enablePriorityUpdate = popValid && popReady;

  // -------------------------------------------------
  // Data selection
  // -------------------------------------------------

  // One-hot OR mux over the flows
  // Grant index is encoded in the same pass
  always_comb begin
    selData = '0;
    selId = '0;
    for (int i = 0; i < NumFlows; i++) begin
      selData |= pushData[i] & {DataWidth{grant[i]}};
      if (grant[i]) begin
        selId |= flowIdT'(i);
      end
    end
  end

  // Tag the beat with its source flow
  always_comb begin
    popPayload.flowId = selId;
    popPayload.data = selData;
  end

endmodule

/* hdl/flowRegFwd.sv */
/* Forward register slice
   One-entry full-throughput pipeline stage for any payload type */

`timescale 1ns/1ps

module flowRegFwd #(
  parameter type PayloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  // Push side
  input  logic    pushValid,
  output logic    pushReady,
  input  PayloadT pushData,
  // Pop side, registered
  output logic    popValid,
  input  logic    popReady,
  output PayloadT popData
);

  // Slot occupancy
  logic beatValid;

  // Held beat
  PayloadT beatData;

  // -------------------------------------------------
  // Flow control
  // -------------------------------------------------

  // Free when empty or emptied this cycle,
  // so back-to-back beats pass without a bubble
  assign pushReady = !beatValid || popReady;

  // Valid follows the push side whenever the slot can take a beat
  always_ff @(posedge clk) begin
    if (reset) begin
      beatValid <= 1'b0;
    end else if (pushReady) begin
      beatValid <= pushValid;
    end
  end

  // -------------------------------------------------
  // Data
  // -------------------------------------------------

  // Loads only on an accepted beat, holds steady while stalled
  always_ff @(posedge clk) begin
    if (pushValid && pushReady) begin
      beatData <= pushData;
    end
  end

  assign popValid = beatValid;
  assign popData = beatData;

endmodule

/* hdl/flowMux.sv */
/* Flow-controlled multiplexer
   Round-robin merge of the push flows into one registered pop flow */

`timescale 1ns/1ps

module flowMux (
  input  logic                      clk,
  input  logic                      reset,
  // Push flows
  input  flowMuxPkg::flowMaskT      pushValid,
  input  flowMuxPkg::flowDataArrayT pushData,
  output flowMuxPkg::flowMaskT      pushReady,
  // Pop flow
  output logic                      popValid,
  input  logic                      popReady,
  output flowMuxPkg::flowPayloadT   popPayload
);

  import flowMuxPkg::*;

  // Arbiter handshake
  flowMaskT request;
  flowMaskT grant;
  logic enablePriorityUpdate;

  // Core to register slice
  logic sliceValid;
  logic sliceReady;
  flowPayloadT slicePayload;

  // -------------------------------------------------
  // Arbitration
  // -------------------------------------------------

  roundRobinArbiter roundRobinArbiter_inst (
    .clk                  (clk),
    .reset                (reset),
    .request              (request),
    .enablePriorityUpdate (enablePriorityUpdate),
    .grant                (grant)
  );

  // -------------------------------------------------
  // Flow control and selection, zero latency
  // -------------------------------------------------

  flowMuxCore flowMuxCore_inst (
    .pushValid            (pushValid),
    .pushData             (pushData),
    .pushReady            (pushReady),
    .request              (request),
    .grant                (grant),
    .enablePriorityUpdate (enablePriorityUpdate),
    .popReady             (sliceReady),
    .popValid             (sliceValid),
    .popPayload           (slicePayload)
  );

  // Registered output stage, stable under pop stalls
  flowRegFwd #(
    .PayloadT (flowPayloadT)
  ) flowRegFwd_inst (
    .clk       (clk),
    .reset     (reset),
    .pushValid (sliceValid),
    .pushReady (sliceReady),
    .pushData  (slicePayload),
    .popValid  (popValid),
    .popReady  (popReady),
    .popData   (popPayload)
  );

endmodule

/* tests/tbClockGen.sv */
/* Testbench clock generator
   Free-running clock, 8 ns period */

`timescale 1ns/1ps

module tbClockGen #(
  parameter real PeriodNs = 8.0
) (
  output logic clk
);

  // Starts low, toggles every half period
  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2.0) clk = ~clk;
  end

endmodule

/* tests/tbFlowMux.sv */
/* Flow multiplexer testbench
   Replays vector streams with pop stalls, checks order, latency and flow control */

`timescale 1ns/1ps

`include "flowMux_config.svh"

module tbFlowMux;

  import flowMuxPkg::*;

  localparam int FlowCount = `FLOW_MUX_NUM_FLOWS;
  localparam int ResetCycles = 16;
  localparam int DrainTimeout = 400;
  // Pop side held ready this long at the start of a stalled phase
  localparam int ReadyHighCycles = 6;

  logic clk;
  logic reset;
  flowMaskT pushValid;
  flowDataArrayT pushData;
  flowMaskT pushReady;
  logic popValid;
  logic popReady;
  flowPayloadT popPayload;

  // Vector file contents, tagged with their phase
  int srcPhase[$];
  flowPayloadT srcBeat[$];
  int expPhase[$];
  flowPayloadT expBeat[$];

  // Per-flow source queues and expected pop order
  flowDataT flowQ[FlowCount][$];
  flowPayloadT expQ[$];

  logic [31:0] lcgState;

  tbClockGen clockGen_inst (
    .clk (clk)
  );

  flowMux flowMux_inst (
    .clk        (clk),
    .reset      (reset),
    .pushValid  (pushValid),
    .pushData   (pushData),
    .pushReady  (pushReady),
    .popValid   (popValid),
    .popReady   (popReady),
    .popPayload (popPayload)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // LCG step, upper bits used by callers
  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkPayload(input string name, input flowPayloadT actual,
                              input flowPayloadT expected);
    if (actual !== expected) begin
      abortRun($sformatf("FAIL %s flow 0x%h data 0x%h, expected flow 0x%h data 0x%h",
                         name, actual.flowId, actual.data, expected.flowId, expected.data));
    end
  endtask

  task automatic checkReady(input string name, input flowMaskT actual,
                            input flowMaskT expected);
    if (actual !== expected) begin
      abortRun($sformatf("FAIL %s 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic checkValid(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abortRun($sformatf("FAIL %s 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // Lines: kind phase flow data, with # comment lines
  task automatic readVectors();
    int fd;
    int count;
    byte kind;
    int phase;
    int flow;
    int data;
    string line;
    flowPayloadT beat;
    fd = $fopen("tests/flowMuxVectors.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open the vector file tests/flowMuxVectors.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      count = $sscanf(line, "%c %d %d %h", kind, phase, flow, data);
      if (count != 4 || flow < 0 || flow >= FlowCount) begin
        abortRun({"malformed line in the vector file: ", line});
      end
      beat.flowId = flowIdT'(flow);
      beat.data = flowDataT'(data);
      if (kind == "S") begin
        srcPhase.push_back(phase);
        srcBeat.push_back(beat);
      end else if (kind == "E") begin
        expPhase.push_back(phase);
        expBeat.push_back(beat);
      end else begin
        abortRun({"unknown line kind in the vector file: ", line});
      end
    end
    $fclose(fd);
  endtask

  // Each flow offers its queue head; valid and data hold until taken
  task automatic driveFlows(input bit stallsOn);
    for (int f = 0; f < FlowCount; f++) begin
      pushValid[f] = (flowQ[f].size() > 0);
      pushData[f] = (flowQ[f].size() > 0) ? flowQ[f][0] : '0;
    end
    // Low about one cycle in three
    popReady = stallsOn ? (((lcgNext() >> 16) % 32'd3) != 32'd0) : 1'b1;
  endtask

  // --------------------------------------------------
  // One test phase, run until every expected beat pops
  // --------------------------------------------------

  task automatic runPhase(input int phase, input bit useStalls);
    int cycles;
    logic allBusy;
    logic heldStall;
    flowMaskT accepted;
    flowPayloadT acceptedBeat;
    flowPayloadT heldBeat;
    for (int i = 0; i < srcBeat.size(); i++) begin
      if (srcPhase[i] == phase) begin
        flowQ[srcBeat[i].flowId].push_back(srcBeat[i].data);
      end
    end
    for (int i = 0; i < expBeat.size(); i++) begin
      if (expPhase[i] == phase) begin
        expQ.push_back(expBeat[i]);
      end
    end
    if (expQ.size() == 0) begin
      abortRun($sformatf("no expected beats for phase %0d in the vector file", phase));
    end
    cycles = 0;
    heldStall = 1'b0;
    accepted = '0;
    acceptedBeat = '0;
    heldBeat = '0;
    while (expQ.size() > 0) begin
      @(posedge clk);
      #1;
      // Retire the beat taken on this edge
      for (int f = 0; f < FlowCount; f++) begin
        if (accepted[f]) begin
          void'(flowQ[f].pop_front());
        end
      end
      driveFlows(useStalls && cycles >= ReadyHighCycles);
      @(negedge clk);
      // Beat taken on the last edge sits at the output now
      if (accepted != '0) begin
        checkValid("popValid after accept", popValid, 1'b1);
        checkPayload("popPayload after accept", popPayload, acceptedBeat);
      end
      // Stalled beat must not move
      if (heldStall) begin
        checkValid("popValid under stall", popValid, 1'b1);
        checkPayload("popPayload under stall", popPayload, heldBeat);
      end
      checkReady("pushReady without pushValid", pushReady & ~pushValid, '0);
      if ($countones(pushReady) > 1) begin
        abortRun($sformatf("FAIL pushReady 0x%h, more than one flow ready", pushReady));
      end
      accepted = pushReady & pushValid;
      for (int f = 0; f < FlowCount; f++) begin
        if (accepted[f]) begin
          acceptedBeat.flowId = flowIdT'(f);
          acceptedBeat.data = flowQ[f][0];
        end
      end
      // Full throughput while every flow waits and the pop side is ready
      allBusy = 1'b1;
      for (int f = 0; f < FlowCount; f++) begin
        if (flowQ[f].size() == 0) begin
          allBusy = 1'b0;
        end
      end
      if (allBusy && popReady && accepted == '0) begin
        abortRun("no beat accepted in a cycle with every flow valid and the pop side ready");
      end
      if (popValid && popReady) begin
        checkPayload("popPayload", popPayload, expQ.pop_front());
      end
      heldStall = popValid && !popReady;
      heldBeat = popPayload;
      cycles++;
      if (cycles > DrainTimeout) begin
        abortRun($sformatf("timeout in phase %0d after %0d cycles, %0d beats never popped",
                           phase, cycles, expQ.size()));
      end
    end
    // One more cycle, nothing may follow the last expected beat
    @(posedge clk);
    #1;
    for (int f = 0; f < FlowCount; f++) begin
      if (accepted[f]) begin
        void'(flowQ[f].pop_front());
      end
    end
    driveFlows(1'b0);
    @(negedge clk);
    checkValid("popValid after last beat", popValid, 1'b0);
    for (int f = 0; f < FlowCount; f++) begin
      if (flowQ[f].size() != 0) begin
        abortRun($sformatf("flow %0d still holds beats after phase %0d", f, phase));
      end
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    lcgState = 32'h6a6720ca;
    reset = 1'b1;
    pushValid = '0;
    pushData = '0;
    popReady = 1'b0;
    readVectors();
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    popReady = 1'b1;
    // Idle output before any push valid
    @(negedge clk);
    checkValid("popValid", popValid, 1'b0);
    checkReady("pushReady", pushReady, '0);
    // Flow 2 alone, then all flows with pop stalls
    runPhase(1, 1'b0);
    runPhase(2, 1'b1);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* project.f */
+incdir+hdl
hdl/flowMuxPkg.sv
hdl/roundRobinArbiter.sv
hdl/flowMuxCore.sv
hdl/flowRegFwd.sv
hdl/flowMux.sv
tests/tbClockGen.sv
tests/tbFlowMux.sv

/* Makefile */
# Verilator build and run of the flow multiplexer testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tbFlowMux
FILELIST  := project.f
OBJDIR    := obj_dir

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := hdl/flowMux_config.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, the header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJDIR)

/* tests/flowMuxVectors.txt */
# Flow multiplexer vectors: kind phase flow data (flow in decimal, data in hex)
# S = source beat on that flow in push order, E = expected popped beat in pop order
# Phase 1: flow 2 alone, pointer ends at flow 3
S 1 2 2a01
S 1 2 2a02
S 1 2 2a03
S 1 2 2a04
# Phase 2: all flows start together, pointer starts at flow 3
S 2 0 1000
S 2 0 1001
S 2 0 1002
S 2 1 1100
S 2 1 1101
S 2 1 1102
S 2 1 1103
S 2 1 1104
S 2 1 1105
S 2 2 1200
S 2 3 1300
S 2 3 1301
# Phase 1 expected order
E 1 2 2a01
E 1 2 2a02
E 1 2 2a03
E 1 2 2a04
# Phase 2 expected order, round robin over flows that still hold beats
E 2 3 1300
E 2 0 1000
E 2 1 1100
E 2 2 1200
E 2 3 1301
E 2 0 1001
E 2 1 1101
E 2 0 1002
E 2 1 1102
E 2 1 1103
E 2 1 1104
E 2 1 1105
